/* Makefile */
SIM      = verilator
TOP      = decodeStageTb
FILELIST = decodeStage.f
FLAGS    = --binary --timing --assert -j 0
BUILDDIR = obj_dir
LOG      = sim.log
PASSMSG  = TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o V$(TOP)

run: build
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* decodeStage.f */
source/decodeIsaPkg.sv
source/decodeCtrlPkg.sv
source/registerFile.sv
source/controlDecoder.sv
source/hazardUnit.sv
source/branchResolver.sv
source/decodeStage.sv
sim/decodeStage_chk.sv
sim/decodeStageTb.sv

/* sim/decodeStageTb.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;

    localparam int  CLK_PERIOD   = 4;
    localparam real SAMPLE_DELAY = 3.5;    // Just before the next rising edge
    localparam int  RESET_CYCLES = 10;
    localparam int  SWEEP_CYCLES = 16;
    localparam int  NUM_CYCLES   = 3000;
    localparam int  TIMEOUT_NS   = (RESET_CYCLES + SWEEP_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

    localparam decodeIsaPkg::opcode_t OPCODES [16] = '{
        decodeIsaPkg::OP_RTYPE, decodeIsaPkg::OP_REGIMM, decodeIsaPkg::OP_J, decodeIsaPkg::OP_JAL,
        decodeIsaPkg::OP_BEQ, decodeIsaPkg::OP_BNE, decodeIsaPkg::OP_BLEZ, decodeIsaPkg::OP_BGTZ,
        decodeIsaPkg::OP_ADDI, decodeIsaPkg::OP_ANDI, decodeIsaPkg::OP_ORI, decodeIsaPkg::OP_LUI,
        decodeIsaPkg::OP_LB, decodeIsaPkg::OP_LW, decodeIsaPkg::OP_SB, decodeIsaPkg::OP_SW
    };

    logic Clock = 1'b0;
    logic rst;
    decodeIsaPkg::instr_t      instruction;
    decodeIsaPkg::word_t       pcPlus4;
    logic                      regWrite;
    decodeIsaPkg::regAddr_t    writeRegister;
    decodeIsaPkg::word_t       writeData;
    logic                      memReadIdEx;
    logic                      regWriteIdEx;
    logic [1:0]                regDstIdEx;
    decodeIsaPkg::regAddr_t    rtIdEx;
    decodeIsaPkg::regAddr_t    rdIdEx;
    logic                      regWriteExMem;
    logic                      memReadExMem;
    decodeIsaPkg::regAddr_t    destExMem;
    decodeCtrlPkg::fwdSel_t    fwdSelA;
    decodeCtrlPkg::fwdSel_t    fwdSelB;
    decodeIsaPkg::word_t       fwdDataExMem;
    decodeIsaPkg::word_t       fwdDataMemWb;
    decodeCtrlPkg::ctrlWord_t  ctrlWord;
    decodeIsaPkg::word_t       readDataA;
    decodeIsaPkg::word_t       readDataB;
    decodeIsaPkg::word_t       immediate;
    decodeIsaPkg::instr_t      outInstruction;
    logic                      jumpTaken;
    logic                      branchTaken;
    decodeIsaPkg::word_t       redirectAddr;
    logic                      flushIf;
    logic                      pcWrite;
    logic                      ifIdWrite;

    decodeIsaPkg::word_t shadowRegs [decodeIsaPkg::REG_COUNT];
    logic [31:0]         rngState = 32'd4885;

    decodeStage dut_i (.*);

    always #(CLK_PERIOD / 2) Clock = ~Clock;

    // ------------------------------------------------------------
    // Random source and error handling
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Small register numbers most of the time, so hazards show up often
    function automatic decodeIsaPkg::regAddr_t pickReg();
        logic [31:0] v;
        v = nextRandom();
        return v[3] ? v[8:4] : {2'b00, v[2:0]};
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkWord(input string name, input decodeIsaPkg::word_t got,
                             input decodeIsaPkg::word_t expected);
        if (got !== expected) begin
            failRun($sformatf("Error %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic checkCtrl(input string name, input decodeCtrlPkg::ctrlWord_t got,
                             input decodeCtrlPkg::ctrlWord_t expected);
        if (got !== expected) begin
            failRun($sformatf("Error %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            failRun($sformatf("Error %s got %h expected %h", name, got, expected));
        end
    endtask

    // ------------------------------------------------------------
    // Reference decode table
    task automatic decodeModel(input decodeIsaPkg::instr_t ins,
                               output decodeCtrlPkg::ctrlWord_t cw,
                               output decodeCtrlPkg::branchCmp_t cmp,
                               output logic jDir, output logic jReg,
                               output logic zext, output logic srcRt);
        decodeIsaPkg::opcode_t op;
        logic [5:0] aluOp;
        logic [1:0] dst;
        logic [1:0] size;
        logic [1:0] wbSel;
        logic       aluImm;
        logic       memWr;
        logic       memRd;
        logic       regWr;
        op = ins[31:26];
        {aluOp, dst, size, wbSel, aluImm, memWr, memRd, regWr} = '0;
        {cmp, jDir, jReg, zext, srcRt} = '0;
        case (op)
            decodeIsaPkg::OP_RTYPE: begin
                srcRt = 1'b1;
                jReg  = (ins[5:0] == decodeIsaPkg::FN_JR);
                if (!jReg) begin
                    {aluOp, dst, regWr} = {ins[5:0], decodeCtrlPkg::REGDST_RD, 1'b1};
                end
            end
            decodeIsaPkg::OP_J:    jDir = 1'b1;
            decodeIsaPkg::OP_JAL:  {jDir, dst, regWr, wbSel} = {1'b1, 2'd2, 1'b1, 2'd2};
            decodeIsaPkg::OP_BEQ:  {cmp, srcRt} = {decodeCtrlPkg::CMP_EQ, 1'b1};
            decodeIsaPkg::OP_BNE:  {cmp, srcRt} = {decodeCtrlPkg::CMP_NE, 1'b1};
            decodeIsaPkg::OP_BLEZ: cmp = decodeCtrlPkg::CMP_LEZ;
            decodeIsaPkg::OP_BGTZ: cmp = decodeCtrlPkg::CMP_GTZ;
            decodeIsaPkg::OP_REGIMM: begin
                if (ins[20:16] == 5'd0) cmp = decodeCtrlPkg::CMP_LTZ;
                if (ins[20:16] == 5'd1) cmp = decodeCtrlPkg::CMP_GEZ;
            end
            decodeIsaPkg::OP_ADDI: {aluOp, aluImm, regWr} = {decodeIsaPkg::FN_ADD, 2'b11};
            decodeIsaPkg::OP_ANDI, decodeIsaPkg::OP_ORI, decodeIsaPkg::OP_LUI: begin
                {aluOp, aluImm, regWr, zext} = {op, 3'b111};
            end
            decodeIsaPkg::OP_LW, decodeIsaPkg::OP_LB: begin
                {aluOp, aluImm, memRd, regWr, wbSel} = {decodeIsaPkg::FN_ADD, 3'b111, 2'd1};
                size = (op == decodeIsaPkg::OP_LB) ? 2'd1 : 2'd0;
            end
            default: begin      // Stores
                {aluOp, aluImm, memWr, srcRt} = {decodeIsaPkg::FN_ADD, 3'b111};
                size = (op == decodeIsaPkg::OP_SB) ? 2'd1 : 2'd0;
            end
        endcase
        cw = {aluOp, aluImm, dst, size, memWr, memRd, 1'b0, regWr, wbSel};  // MSB first
    endtask

    function automatic decodeIsaPkg::word_t modelRead(input decodeIsaPkg::regAddr_t addr,
                                                      input decodeCtrlPkg::fwdSel_t sel);
        decodeIsaPkg::word_t value;
        value = shadowRegs[addr];
        if (regWrite && writeRegister == addr) value = writeData;   // Write-through
        if (addr == 5'd0) value = '0;
        if (sel == decodeCtrlPkg::FWD_EXMEM) value = fwdDataExMem;
        if (sel == decodeCtrlPkg::FWD_MEMWB) value = fwdDataMemWb;
        return value;
    endfunction

    // ------------------------------------------------------------
    // Stimulus
    task automatic driveRandom();
        logic [31:0] r;
        decodeIsaPkg::instr_t ins;
        r = nextRandom();
        ins = nextRandom();
        ins[31:26] = OPCODES[r[3:0]];
        ins[25:21] = pickReg();
        ins[20:16] = pickReg();
        if (ins[31:26] == decodeIsaPkg::OP_RTYPE && r[4]) ins[5:0] = decodeIsaPkg::FN_JR;
        if (ins[31:26] == decodeIsaPkg::OP_REGIMM) ins[20:16] = {3'b000, r[6:5]};
        instruction   <= ins;
        pcPlus4       <= {r[31:20], ins[19:2], 2'b00};
        regWrite      <= r[7];
        writeRegister <= pickReg();
        writeData     <= nextRandom();
        memReadIdEx   <= r[8] & r[9];
        regWriteIdEx  <= r[10];
        regDstIdEx    <= r[12:11];
        rtIdEx        <= pickReg();
        rdIdEx        <= pickReg();
        regWriteExMem <= r[13];
        memReadExMem  <= r[14];
        destExMem     <= pickReg();
        fwdSelA       <= r[16:15];       // 3 falls back to the register value
        fwdSelB       <= r[18:17];
        fwdDataExMem  <= nextRandom();
        fwdDataMemWb  <= nextRandom();
    endtask

    task automatic checkOutputs();
        decodeCtrlPkg::ctrlWord_t   cw;
        decodeCtrlPkg::branchCmp_t  cmp;
        decodeIsaPkg::regAddr_t     rs;
        decodeIsaPkg::regAddr_t     rt;
        decodeIsaPkg::regAddr_t     destEx;
        decodeIsaPkg::word_t        opA;
        decodeIsaPkg::word_t        opB;
        decodeIsaPkg::word_t        imm;
        decodeIsaPkg::word_t        target;
        logic jDir, jReg, zext, srcRt, hitEx, hitMem, isBr, stallExp, taken, flushExp;
        decodeModel(instruction, cw, cmp, jDir, jReg, zext, srcRt);
        rs  = instruction[25:21];
        rt  = instruction[20:16];
        opA = modelRead(rs, fwdSelA);
        opB = modelRead(rt, fwdSelB);
        imm = zext ? {16'h0, instruction[15:0]} : {{16{instruction[15]}}, instruction[15:0]};

        destEx   = (regDstIdEx == decodeCtrlPkg::REGDST_RT) ? rtIdEx : rdIdEx;
        hitEx    = destEx != 5'd0 && (destEx == rs || (srcRt && destEx == rt));
        hitMem   = destExMem != 5'd0 && (destExMem == rs || (srcRt && destExMem == rt));
        isBr     = cmp != decodeCtrlPkg::CMP_NONE || jReg;
        stallExp = (memReadIdEx && hitEx) || (isBr && regWriteIdEx && hitEx) ||
                   (isBr && memReadExMem && regWriteExMem && hitMem);

        case (cmp)
            decodeCtrlPkg::CMP_EQ:  taken = opA == opB;
            decodeCtrlPkg::CMP_NE:  taken = opA != opB;
            decodeCtrlPkg::CMP_LEZ: taken = $signed(opA) <= 32'sd0;
            decodeCtrlPkg::CMP_GTZ: taken = $signed(opA) > 32'sd0;
            decodeCtrlPkg::CMP_LTZ: taken = $signed(opA) < 32'sd0;
            decodeCtrlPkg::CMP_GEZ: taken = $signed(opA) >= 32'sd0;
            default:                taken = 1'b0;
        endcase
        target = jReg ? opA : jDir ? {pcPlus4[31:28], instruction[25:0], 2'b00}
                                   : pcPlus4 + (imm << 2);
        flushExp = (taken || jDir || jReg) && !stallExp;

        checkWord("outInstruction", outInstruction, instruction);
        checkWord("immediate", immediate, imm);
        checkWord("readDataA", readDataA, opA);
        checkWord("readDataB", readDataB, opB);
        checkBit("pcWrite", pcWrite, !stallExp);
        checkBit("ifIdWrite", ifIdWrite, !stallExp);
        checkCtrl("ctrlWord", ctrlWord, stallExp ? '0 : cw);
        checkBit("branchTaken", branchTaken, taken && !stallExp);
        checkBit("jumpTaken", jumpTaken, (jDir || jReg) && !stallExp);
        checkBit("flushIf", flushIf, flushExp);
        if (flushExp) checkWord("redirectAddr", redirectAddr, target);

        if (regWrite && writeRegister != 5'd0) shadowRegs[writeRegister] = writeData;
    endtask

    // ------------------------------------------------------------
    // Run
    initial begin
        rst <= 1'b1;
        {instruction, pcPlus4, regWrite, writeRegister, writeData} <= '0;
        {memReadIdEx, regWriteIdEx, regDstIdEx, rtIdEx, rdIdEx} <= '0;
        {regWriteExMem, memReadExMem, destExMem, fwdSelA, fwdSelB} <= '0;
        {fwdDataExMem, fwdDataMemWb} <= '0;
        for (int i = 0; i < decodeIsaPkg::REG_COUNT; i++) shadowRegs[i] = '0;
        for (int i = 0; i < RESET_CYCLES; i++) @(posedge Clock);
        rst <= 1'b0;

        // Every register must read zero after reset
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            @(posedge Clock);
            instruction <= {6'h00, 5'(2 * i), 5'(2 * i + 1), 10'h0, decodeIsaPkg::FN_ADD};
            #(SAMPLE_DELAY);
            checkOutputs();
        end

        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge Clock);
            driveRandom();
            #(SAMPLE_DELAY);
            checkOutputs();
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        failRun("Simulation did not finish within the time limit");
    end

endmodule

`default_nettype wire

/* sim/decodeStage_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStageChk (
    input logic Clock,
    input logic rst,
    input logic pcWrite,
    input logic ifIdWrite,
    input logic flushIf,
    input logic branchTaken,
    input logic jumpTaken,
    input logic memReadIdEx,
    input logic regWriteIdEx,
    input logic memReadExMem
);

    // ------------------------------------------------------------
    // Stall and flush consistency
    stallNeedsProducer: assert property (@(posedge Clock) disable iff (rst)
        !pcWrite |-> (memReadIdEx || regWriteIdEx || memReadExMem))
        else $error("Stall with no load or register write in flight");

    holdBlocksFlush: assert property (@(posedge Clock) disable iff (rst)
        !ifIdWrite |-> !flushIf)
        else $error("Fetch flushed while its register is held");

    singleRedirectCause: assert property (@(posedge Clock) disable iff (rst)
        !(branchTaken && jumpTaken))
        else $error("Branch and jump taken in the same cycle");

endmodule

bind decodeStage decodeStageChk chk_i (
    .Clock        (Clock),
    .rst          (rst),
    .pcWrite      (pcWrite),
    .ifIdWrite    (ifIdWrite),
    .flushIf      (flushIf),
    .branchTaken  (branchTaken),
    .jumpTaken    (jumpTaken),
    .memReadIdEx  (memReadIdEx),
    .regWriteIdEx (regWriteIdEx),
    .memReadExMem (memReadExMem)
);

`default_nettype wire

/* source/branchResolver.sv */
`timescale 1ns/10ps
`default_nettype none

module branchResolver (
    input  decodeIsaPkg::word_t                     operandA,
    input  decodeIsaPkg::word_t                     operandB,
    input  decodeCtrlPkg::branchCmp_t               branchCmp,
    input  logic                                    jumpDirect,
    input  logic                                    jumpRegister,
    input  logic                                    stall,
    input  decodeIsaPkg::word_t                     immediate,
    input  logic [decodeIsaPkg::TARGET_WIDTH-1:0]   jumpTarget,
    input  decodeIsaPkg::word_t                     pcPlus4,
    output logic                                    branchTaken,
    output logic                                    jumpTaken,
    output decodeIsaPkg::word_t                     redirectAddr,
    output logic                                    flushIf
);

    logic                cmpResult;
    decodeIsaPkg::word_t branchTarget;
    decodeIsaPkg::word_t directTarget;

    // ------------------------------------------------------------
    // Signed comparison on forwarded operands
    always_comb begin
        case (branchCmp)
            decodeCtrlPkg::CMP_EQ:  cmpResult = (operandA == operandB);
            decodeCtrlPkg::CMP_NE:  cmpResult = (operandA != operandB);
            decodeCtrlPkg::CMP_LEZ: cmpResult = ($signed(operandA) <= 0);
            decodeCtrlPkg::CMP_GTZ: cmpResult = ($signed(operandA) > 0);
            decodeCtrlPkg::CMP_LTZ: cmpResult = operandA[31];   // Sign bit only
            decodeCtrlPkg::CMP_GEZ: cmpResult = !operandA[31];
            default:                cmpResult = 1'b0;
        endcase
    end

    // Nothing leaves decode while stalled
    assign branchTaken = cmpResult && !stall;
    assign jumpTaken   = (jumpDirect || jumpRegister) && !stall;
    assign flushIf     = branchTaken || jumpTaken;

    assign branchTarget = pcPlus4 + {immediate[29:0], 2'b00};
    assign directTarget = {pcPlus4[31:28], jumpTarget, 2'b00};  // Same 256 MB region

    always_comb begin
        if (jumpRegister) begin
            redirectAddr = operandA;
        end else if (jumpDirect) begin
            redirectAddr = directTarget;
        end else begin
            redirectAddr = branchTarget;
        end
    end

endmodule

`default_nettype wire

/* source/controlDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
    input  decodeIsaPkg::instr_t      instruction,
    output decodeCtrlPkg::ctrlWord_t  ctrlWord,
    output decodeCtrlPkg::branchCmp_t branchCmp,
    output logic                      jumpDirect,
    output logic                      jumpRegister,
    output logic                      zeroExtend,
    output logic                      usesRt
);

    decodeIsaPkg::opcode_t  opcode;
    decodeIsaPkg::funct_t   funct;
    decodeIsaPkg::regAddr_t rtField;

    logic [decodeCtrlPkg::ALUOP_WIDTH-1:0] aluOp;
    logic       aluSrcImm;
    logic [1:0] regDst;
    logic [1:0] byteSize;
    logic       memWrite;
    logic       memRead;
    logic       regWrite;
    logic [1:0] memToReg;

    assign opcode  = instruction[decodeIsaPkg::OPCODE_LSB +: decodeIsaPkg::OPCODE_WIDTH];
    assign funct   = instruction[decodeIsaPkg::FUNCT_LSB +: decodeIsaPkg::FUNCT_WIDTH];
    assign rtField = instruction[decodeIsaPkg::RT_LSB +: decodeIsaPkg::REG_ADDR_WIDTH];

    // ------------------------------------------------------------
    // Opcode table
    always_comb begin
        aluOp        = '0;
        aluSrcImm    = 1'b0;
        regDst       = decodeCtrlPkg::REGDST_RT;
        byteSize     = decodeCtrlPkg::SIZE_WORD;
        memWrite     = 1'b0;
        memRead      = 1'b0;
        regWrite     = 1'b0;
        memToReg     = decodeCtrlPkg::MEMTOREG_ALU;
        branchCmp    = decodeCtrlPkg::CMP_NONE;
        jumpDirect   = 1'b0;
        jumpRegister = 1'b0;
        zeroExtend   = 1'b0;
        usesRt       = 1'b0;

        case (opcode)
            decodeIsaPkg::OP_RTYPE: begin
                usesRt = 1'b1;
                if (funct == decodeIsaPkg::FN_JR) begin
                    jumpRegister = 1'b1;
                end else begin
                    aluOp    = funct;          // ALU sees the function code directly
                    regDst   = decodeCtrlPkg::REGDST_RD;
                    regWrite = 1'b1;
                end
            end
            decodeIsaPkg::OP_J: jumpDirect = 1'b1;
            decodeIsaPkg::OP_JAL: begin
                jumpDirect = 1'b1;
                regDst     = decodeCtrlPkg::REGDST_RA;
                regWrite   = 1'b1;
                memToReg   = decodeCtrlPkg::MEMTOREG_PC4;  // Link address
            end
            decodeIsaPkg::OP_BEQ: begin
                branchCmp = decodeCtrlPkg::CMP_EQ;
                usesRt    = 1'b1;
            end
            decodeIsaPkg::OP_BNE: begin
                branchCmp = decodeCtrlPkg::CMP_NE;
                usesRt    = 1'b1;
            end
            decodeIsaPkg::OP_BLEZ: branchCmp = decodeCtrlPkg::CMP_LEZ;
            decodeIsaPkg::OP_BGTZ: branchCmp = decodeCtrlPkg::CMP_GTZ;
            decodeIsaPkg::OP_REGIMM: begin
                // rt selects the comparison, it is not a source
                if (rtField == decodeIsaPkg::RT_BLTZ) begin
                    branchCmp = decodeCtrlPkg::CMP_LTZ;
                end else if (rtField == decodeIsaPkg::RT_BGEZ) begin
                    branchCmp = decodeCtrlPkg::CMP_GEZ;
                end
            end
            decodeIsaPkg::OP_ADDI: begin
                aluOp     = decodeIsaPkg::FN_ADD;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            decodeIsaPkg::OP_ANDI, decodeIsaPkg::OP_ORI, decodeIsaPkg::OP_LUI: begin
                aluOp      = opcode;           // Logical immediates keep their opcode
                aluSrcImm  = 1'b1;
                regWrite   = 1'b1;
                zeroExtend = 1'b1;
            end
            decodeIsaPkg::OP_LW, decodeIsaPkg::OP_LB: begin
                aluOp     = decodeIsaPkg::FN_ADD;  // Address = base + offset
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
                memToReg  = decodeCtrlPkg::MEMTOREG_MEM;
                if (opcode == decodeIsaPkg::OP_LB) begin
                    byteSize = decodeCtrlPkg::SIZE_BYTE;
                end
            end
            decodeIsaPkg::OP_SW, decodeIsaPkg::OP_SB: begin
                aluOp     = decodeIsaPkg::FN_ADD;
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                usesRt    = 1'b1;              // Store data
                if (opcode == decodeIsaPkg::OP_SB) begin
                    byteSize = decodeCtrlPkg::SIZE_BYTE;
                end
            end
            default: ;
        endcase
    end

    // Pack the fields
    always_comb begin
        ctrlWord = '0;
        ctrlWord[decodeCtrlPkg::CW_ALUOP +: decodeCtrlPkg::ALUOP_WIDTH] = aluOp;
        ctrlWord[decodeCtrlPkg::CW_ALUSRC]         = aluSrcImm;
        ctrlWord[decodeCtrlPkg::CW_REGDST +: 2]    = regDst;
        ctrlWord[decodeCtrlPkg::CW_BYTESIZE +: 2]  = byteSize;
        ctrlWord[decodeCtrlPkg::CW_MEMWRITE]       = memWrite;
        ctrlWord[decodeCtrlPkg::CW_MEMREAD]        = memRead;
        ctrlWord[decodeCtrlPkg::CW_SPARE]          = 1'b0;
        ctrlWord[decodeCtrlPkg::CW_REGWRITE]       = regWrite;
        ctrlWord[decodeCtrlPkg::CW_MEMTOREG +: 2]  = memToReg;
    end

endmodule

`default_nettype wire

/* source/decodeCtrlPkg.sv */
`default_nettype none

package decodeCtrlPkg;

    localparam int CTRL_WIDTH  = 17;
    localparam int ALUOP_WIDTH = 6;

    typedef logic [CTRL_WIDTH-1:0] ctrlWord_t;

    // ------------------------------------------------------------
    // Control word layout, LSB of each field
    localparam int CW_MEMTOREG = 0;     // 2 bits
    localparam int CW_REGWRITE = 2;
    localparam int CW_SPARE    = 3;     // Reserved, always zero
    localparam int CW_MEMREAD  = 4;
    localparam int CW_MEMWRITE = 5;
    localparam int CW_BYTESIZE = 6;     // 2 bits
    localparam int CW_REGDST   = 8;     // 2 bits
    localparam int CW_ALUSRC   = 10;
    localparam int CW_ALUOP    = 11;    // 6 bits

    localparam logic [1:0] REGDST_RT = 2'd0;
    localparam logic [1:0] REGDST_RD = 2'd1;
    localparam logic [1:0] REGDST_RA = 2'd2;    // Link register 31

    localparam logic [1:0] MEMTOREG_ALU = 2'd0;
    localparam logic [1:0] MEMTOREG_MEM = 2'd1;
    localparam logic [1:0] MEMTOREG_PC4 = 2'd2;

    localparam logic [1:0] SIZE_WORD = 2'd0;
    localparam logic [1:0] SIZE_BYTE = 2'd1;

    // ------------------------------------------------------------
    // Branch comparison codes
    typedef logic [2:0] branchCmp_t;
    localparam branchCmp_t CMP_NONE = 3'd0;
    localparam branchCmp_t CMP_EQ   = 3'd1;
    localparam branchCmp_t CMP_NE   = 3'd2;
    localparam branchCmp_t CMP_LEZ  = 3'd3;
    localparam branchCmp_t CMP_GTZ  = 3'd4;
    localparam branchCmp_t CMP_LTZ  = 3'd5;
    localparam branchCmp_t CMP_GEZ  = 3'd6;

    typedef logic [1:0] fwdSel_t;
    localparam fwdSel_t FWD_REG   = 2'd0;
    localparam fwdSel_t FWD_EXMEM = 2'd1;
    localparam fwdSel_t FWD_MEMWB = 2'd2;

endpackage

`default_nettype wire

/* source/decodeIsaPkg.sv */
`default_nettype none

package decodeIsaPkg;

    localparam int WORD_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int OPCODE_WIDTH   = 6;
    localparam int FUNCT_WIDTH    = 6;
    localparam int IMM_WIDTH      = 16;
    localparam int TARGET_WIDTH   = 26;
    localparam int REG_COUNT      = 32;

    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [WORD_WIDTH-1:0]     instr_t;
    typedef logic [REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [OPCODE_WIDTH-1:0]   opcode_t;
    typedef logic [FUNCT_WIDTH-1:0]    funct_t;

    // ------------------------------------------------------------
    // Field positions (LSB of each field)
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int IMM_LSB    = 0;
    localparam int TARGET_LSB = 0;
    localparam int FUNCT_LSB  = 0;

    // ------------------------------------------------------------
    // Opcodes
    localparam opcode_t OP_RTYPE  = 6'h00;
    localparam opcode_t OP_REGIMM = 6'h01;
    localparam opcode_t OP_J      = 6'h02;
    localparam opcode_t OP_JAL    = 6'h03;
    localparam opcode_t OP_BEQ    = 6'h04;
    localparam opcode_t OP_BNE    = 6'h05;
    localparam opcode_t OP_BLEZ   = 6'h06;
    localparam opcode_t OP_BGTZ   = 6'h07;
    localparam opcode_t OP_ADDI   = 6'h08;
    localparam opcode_t OP_ANDI   = 6'h0c;
    localparam opcode_t OP_ORI    = 6'h0d;
    localparam opcode_t OP_LUI    = 6'h0f;
    localparam opcode_t OP_LB     = 6'h20;
    localparam opcode_t OP_LW     = 6'h23;
    localparam opcode_t OP_SB     = 6'h28;
    localparam opcode_t OP_SW     = 6'h2b;

    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;

    // REGIMM sub-opcodes carried in rt
    localparam regAddr_t RT_BLTZ = 5'd0;
    localparam regAddr_t RT_BGEZ = 5'd1;

endpackage

`default_nettype wire

/* source/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  logic                      Clock,
    input  logic                      rst,
    input  decodeIsaPkg::instr_t      instruction,
    input  decodeIsaPkg::word_t       pcPlus4,
    input  logic                      regWrite,
    input  decodeIsaPkg::regAddr_t    writeRegister,
    input  decodeIsaPkg::word_t       writeData,
    input  logic                      memReadIdEx,
    input  logic                      regWriteIdEx,
    input  logic [1:0]                regDstIdEx,
    input  decodeIsaPkg::regAddr_t    rtIdEx,
    input  decodeIsaPkg::regAddr_t    rdIdEx,
    input  logic                      regWriteExMem,
    input  logic                      memReadExMem,
    input  decodeIsaPkg::regAddr_t    destExMem,
    input  decodeCtrlPkg::fwdSel_t    fwdSelA,
    input  decodeCtrlPkg::fwdSel_t    fwdSelB,
    input  decodeIsaPkg::word_t       fwdDataExMem,
    input  decodeIsaPkg::word_t       fwdDataMemWb,
    output decodeCtrlPkg::ctrlWord_t  ctrlWord,
    output decodeIsaPkg::word_t       readDataA,
    output decodeIsaPkg::word_t       readDataB,
    output decodeIsaPkg::word_t       immediate,
    output decodeIsaPkg::instr_t      outInstruction,
    output logic                      jumpTaken,
    output logic                      branchTaken,
    output decodeIsaPkg::word_t       redirectAddr,
    output logic                      flushIf,
    output logic                      pcWrite,
    output logic                      ifIdWrite
);

    decodeIsaPkg::regAddr_t    rs;
    decodeIsaPkg::regAddr_t    rt;
    logic [decodeIsaPkg::IMM_WIDTH-1:0] immField;
    decodeIsaPkg::word_t       regDataA;
    decodeIsaPkg::word_t       regDataB;
    decodeCtrlPkg::ctrlWord_t  rawCtrl;
    decodeCtrlPkg::branchCmp_t branchCmp;
    logic                      jumpDirect;
    logic                      jumpRegister;
    logic                      zeroExtend;
    logic                      usesRt;
    logic                      isBranch;
    logic                      stall;

    function automatic decodeIsaPkg::word_t fwdMux(
        input decodeCtrlPkg::fwdSel_t sel,
        input decodeIsaPkg::word_t    regValue,
        input decodeIsaPkg::word_t    exMemValue,
        input decodeIsaPkg::word_t    memWbValue
    );
        case (sel)
            decodeCtrlPkg::FWD_REG:   return regValue;
            decodeCtrlPkg::FWD_EXMEM: return exMemValue;
            decodeCtrlPkg::FWD_MEMWB: return memWbValue;
            default:                  return regValue;
        endcase
    endfunction

    assign rs       = instruction[decodeIsaPkg::RS_LSB +: decodeIsaPkg::REG_ADDR_WIDTH];
    assign rt       = instruction[decodeIsaPkg::RT_LSB +: decodeIsaPkg::REG_ADDR_WIDTH];
    assign immField = instruction[decodeIsaPkg::IMM_LSB +: decodeIsaPkg::IMM_WIDTH];

    assign outInstruction = instruction;

    registerFile regFile (
        .Clock     (Clock),
        .rst       (rst),
        .readAddrA (rs),
        .readAddrB (rt),
        .writeAddr (writeRegister),
        .writeData (writeData),
        .writeEn   (regWrite),
        .readDataA (regDataA),
        .readDataB (regDataB)
    );

    controlDecoder ctrlDec (
        .instruction  (instruction),
        .ctrlWord     (rawCtrl),
        .branchCmp    (branchCmp),
        .jumpDirect   (jumpDirect),
        .jumpRegister (jumpRegister),
        .zeroExtend   (zeroExtend),
        .usesRt       (usesRt)
    );

    // ------------------------------------------------------------
    // Operand forwarding and immediate
    always_comb begin
        readDataA = fwdMux(fwdSelA, regDataA, fwdDataExMem, fwdDataMemWb);
        readDataB = fwdMux(fwdSelB, regDataB, fwdDataExMem, fwdDataMemWb);
    end

    assign immediate = zeroExtend ? {16'b0, immField} : {{16{immField[15]}}, immField};

    // ------------------------------------------------------------
    // Hazards and early branch resolution
    assign isBranch = (branchCmp != decodeCtrlPkg::CMP_NONE) || jumpRegister;

    hazardUnit hazard (
        .rs           (rs),
        .rt           (rt),
        .usesRt       (usesRt),
        .isBranch     (isBranch),
        .memReadIdEx  (memReadIdEx),
        .regWriteIdEx (regWriteIdEx),
        .regDstIdEx   (regDstIdEx),
        .rtIdEx       (rtIdEx),
        .rdIdEx       (rdIdEx),
        .memReadExMem (memReadExMem && regWriteExMem),  // Load that writes a register
        .destExMem    (destExMem),
        .stall        (stall)
    );

    branchResolver resolver (
        .operandA     (readDataA),
        .operandB     (readDataB),
        .branchCmp    (branchCmp),
        .jumpDirect   (jumpDirect),
        .jumpRegister (jumpRegister),
        .stall        (stall),
        .immediate    (immediate),
        .jumpTarget   (instruction[decodeIsaPkg::TARGET_LSB +: decodeIsaPkg::TARGET_WIDTH]),
        .pcPlus4      (pcPlus4),
        .branchTaken  (branchTaken),
        .jumpTaken    (jumpTaken),
        .redirectAddr (redirectAddr),
        .flushIf      (flushIf)
    );

    // Bubble into execute, fetch holds
    assign ctrlWord  = stall ? '0 : rawCtrl;
    assign pcWrite   = !stall;
    assign ifIdWrite = !stall;

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  decodeIsaPkg::regAddr_t rs,
    input  decodeIsaPkg::regAddr_t rt,
    input  logic                   usesRt,
    input  logic                   isBranch,
    input  logic                   memReadIdEx,
    input  logic                   regWriteIdEx,
    input  logic [1:0]             regDstIdEx,
    input  decodeIsaPkg::regAddr_t rtIdEx,
    input  decodeIsaPkg::regAddr_t rdIdEx,
    input  logic                   memReadExMem,
    input  decodeIsaPkg::regAddr_t destExMem,
    output logic                   stall
);

    decodeIsaPkg::regAddr_t destIdEx;
    logic hitIdEx;
    logic hitExMem;
    logic loadUse;
    logic branchIdEx;
    logic branchExMem;

    assign destIdEx = (regDstIdEx == decodeCtrlPkg::REGDST_RT) ? rtIdEx : rdIdEx;

    // ------------------------------------------------------------
    // Source matches, r0 never creates a dependency
    assign hitIdEx  = (destIdEx != '0) &&
                      ((destIdEx == rs) || (usesRt && (destIdEx == rt)));
    assign hitExMem = (destExMem != '0) &&
                      ((destExMem == rs) || (usesRt && (destExMem == rt)));

    assign loadUse     = memReadIdEx && hitIdEx;
    assign branchIdEx  = isBranch && regWriteIdEx && hitIdEx;   // Result not yet computed
    assign branchExMem = isBranch && memReadExMem && hitExMem;  // Load data still in memory

    assign stall = loadUse || branchIdEx || branchExMem;

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input  logic                   Clock,
    input  logic                   rst,
    input  decodeIsaPkg::regAddr_t readAddrA,
    input  decodeIsaPkg::regAddr_t readAddrB,
    input  decodeIsaPkg::regAddr_t writeAddr,
    input  decodeIsaPkg::word_t    writeData,
    input  logic                   writeEn,
    output decodeIsaPkg::word_t    readDataA,
    output decodeIsaPkg::word_t    readDataB
);

    decodeIsaPkg::word_t regs [decodeIsaPkg::REG_COUNT];

    // r0 is hardwired, a pending write is bypassed to the reader
    function automatic decodeIsaPkg::word_t readPort(input decodeIsaPkg::regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (writeEn && (writeAddr == addr)) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < decodeIsaPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire
